/* Bender.yml */
package:
  name: core_mem

sources:
  - core_mem_pkg.sv
  - core_lane_aligner.sv
  - core_wb_bridge.sv
  - wb_rr_arbiter.sv
  - wb_sram.sv
  - core_mem_top.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - tb_core_mem_checker.sv
      - tb_core_mem_top.sv

/* core_lane_aligner.sv */
`timescale 1ns/1ps

module core_lane_aligner (
    input  core_mem_pkg::addr_t  core_addr_i [core_mem_pkg::num_ports],
    input  logic                 core_cmd_i,   // Data port, 1 = write
    input  core_mem_pkg::width_t core_width_i, // Data port access width
    input  core_mem_pkg::data_t  core_wdata_i, // Data port store data

    output core_mem_pkg::addr_t  lane_addr_o  [core_mem_pkg::num_ports],
    output core_mem_pkg::sel_t   lane_sel_o   [core_mem_pkg::num_ports],
    output logic [core_mem_pkg::num_ports-1:0] lane_we_o,
    output core_mem_pkg::data_t  lane_wdata_o [core_mem_pkg::num_ports]
);

    // Byte lanes touched by an access of the given width
    function automatic core_mem_pkg::sel_t width_to_sel(
        input core_mem_pkg::width_t width,
        input logic [1:0]           offset
    );
        core_mem_pkg::sel_t sel;
        case (width)
            core_mem_pkg::width_byte: sel = 4'b0001 << offset;
            core_mem_pkg::width_half: sel = offset[1] ? 4'b1100 : 4'b0011;
            default:                  sel = 4'b1111; // Word, and the unused code
        endcase
        return sel;
    endfunction

    // Copy the narrow value into every lane so the selected one carries it
    function automatic core_mem_pkg::data_t replicate(
        input core_mem_pkg::width_t width,
        input core_mem_pkg::data_t  data
    );
        core_mem_pkg::data_t lanes;
        case (width)
            core_mem_pkg::width_byte: lanes = {4{data[7:0]}};
            core_mem_pkg::width_half: lanes = {2{data[15:0]}};
            default:                  lanes = data;
        endcase
        return lanes;
    endfunction

    // Memory is word organised, so both ports present aligned addresses
    genvar p;
    generate
        for (p = 0; p < core_mem_pkg::num_ports; p++) begin : g_align
            assign lane_addr_o[p] = {core_addr_i[p][31:2], 2'b00};
        end
    endgenerate

    // Instruction port, always a full word read
    assign lane_sel_o[0]   = 4'b1111;
    assign lane_we_o[0]    = 1'b0;
    assign lane_wdata_o[0] = '0;

    // Data port
    assign lane_sel_o[1]   = width_to_sel(core_width_i, core_addr_i[1][1:0]);
    assign lane_we_o[1]    = core_cmd_i;
    assign lane_wdata_o[1] = replicate(core_width_i, core_wdata_i);

endmodule

/* core_mem_pkg.sv */
package core_mem_pkg;

    // Port 0 fetches instructions, port 1 is the load/store port
    localparam int num_ports = 2;

    // Block RAM depth in 32-bit words
    localparam int mem_words = 256;

    typedef logic [31:0] addr_t;  // Byte address
    typedef logic [31:0] data_t;  // Data word
    typedef logic [3:0]  sel_t;   // Wishbone byte lanes
    typedef logic [1:0]  width_t; // Core access width

    typedef logic [$clog2(mem_words)-1:0] mem_idx_t;
    typedef logic [$clog2(num_ports)-1:0] port_idx_t;

    // Access width codes as driven by the core
    localparam width_t width_byte = 2'b00;
    localparam width_t width_half = 2'b01;
    localparam width_t width_word = 2'b10;

    // Request bridge FSM
    typedef enum logic [1:0] {
        st_idle = 2'b00, // Waiting for a core request
        st_bus  = 2'b01, // Wishbone cycle open
        st_resp = 2'b10  // Response given, waiting for req to drop
    } bridge_state_t;

endpackage

/* core_mem_top.sv */
`timescale 1ns/1ps

module core_mem_top (
    input  logic                 clk_core,
    input  logic                 reset_i,

    // Instruction port, read only
    input  logic                 imem_req_i,
    input  core_mem_pkg::addr_t  imem_addr_i,
    output logic                 imem_resp_o,
    output core_mem_pkg::data_t  imem_rdata_o,

    // Data port
    input  logic                 dmem_req_i,
    input  logic                 dmem_cmd_i,   // 1 = write
    input  core_mem_pkg::width_t dmem_width_i,
    input  core_mem_pkg::addr_t  dmem_addr_i,
    input  core_mem_pkg::data_t  dmem_wdata_i,
    output logic                 dmem_resp_o,
    output core_mem_pkg::data_t  dmem_rdata_o
);

    localparam int np = core_mem_pkg::num_ports;

    // Core requests gathered per port
    logic [np-1:0]       core_req;
    core_mem_pkg::addr_t core_addr [np];

    // Aligner to bridges
    core_mem_pkg::addr_t lane_addr  [np];
    core_mem_pkg::sel_t  lane_sel   [np];
    logic [np-1:0]       lane_we;
    core_mem_pkg::data_t lane_wdata [np];

    // Bridges to arbiter
    logic [np-1:0]       br_cyc;
    logic [np-1:0]       br_stb;
    logic [np-1:0]       br_we;
    core_mem_pkg::addr_t br_addr  [np];
    core_mem_pkg::sel_t  br_sel   [np];
    core_mem_pkg::data_t br_wdata [np];
    logic [np-1:0]       br_ack;
    core_mem_pkg::data_t br_rdata [np];

    // Responses to the core
    logic [np-1:0]       resp;
    core_mem_pkg::data_t rdata [np];

    // Arbiter to memory
    logic                mem_cyc;
    logic                mem_stb;
    logic                mem_we;
    core_mem_pkg::addr_t mem_addr;
    core_mem_pkg::sel_t  mem_sel;
    core_mem_pkg::data_t mem_wdata;
    logic                mem_ack;
    core_mem_pkg::data_t mem_rdata;

    assign core_req     = {dmem_req_i, imem_req_i};
    assign core_addr[0] = imem_addr_i;
    assign core_addr[1] = dmem_addr_i;

    assign imem_resp_o  = resp[0];
    assign imem_rdata_o = rdata[0];
    assign dmem_resp_o  = resp[1];
    assign dmem_rdata_o = rdata[1];

    core_lane_aligner u_aligner (
        .core_addr_i  (core_addr),
        .core_cmd_i   (dmem_cmd_i),
        .core_width_i (dmem_width_i),
        .core_wdata_i (dmem_wdata_i),
        .lane_addr_o  (lane_addr),
        .lane_sel_o   (lane_sel),
        .lane_we_o    (lane_we),
        .lane_wdata_o (lane_wdata)
    );

    genvar p;
    generate
        for (p = 0; p < np; p++) begin : g_bridge
            core_wb_bridge u_bridge (
                .clk_core   (clk_core),
                .reset_i    (reset_i),
                .req_i      (core_req[p]),
                .addr_i     (lane_addr[p]),
                .sel_i      (lane_sel[p]),
                .we_i       (lane_we[p]),
                .wdata_i    (lane_wdata[p]),
                .wb_ack_i   (br_ack[p]),
                .wb_rdata_i (br_rdata[p]),
                .wb_cyc_o   (br_cyc[p]),
                .wb_stb_o   (br_stb[p]),
                .wb_we_o    (br_we[p]),
                .wb_addr_o  (br_addr[p]),
                .wb_sel_o   (br_sel[p]),
                .wb_wdata_o (br_wdata[p]),
                .resp_o     (resp[p]),
                .rdata_o    (rdata[p])
            );
        end
    endgenerate

    wb_rr_arbiter u_arbiter (
        .clk_core  (clk_core),
        .reset_i   (reset_i),
        .m_cyc_i   (br_cyc),
        .m_stb_i   (br_stb),
        .m_we_i    (br_we),
        .m_addr_i  (br_addr),
        .m_sel_i   (br_sel),
        .m_wdata_i (br_wdata),
        .m_ack_o   (br_ack),
        .m_rdata_o (br_rdata),
        .s_ack_i   (mem_ack),
        .s_rdata_i (mem_rdata),
        .s_cyc_o   (mem_cyc),
        .s_stb_o   (mem_stb),
        .s_we_o    (mem_we),
        .s_addr_o  (mem_addr),
        .s_sel_o   (mem_sel),
        .s_wdata_o (mem_wdata)
    );

    wb_sram u_sram (
        .clk_core (clk_core),
        .reset_i  (reset_i),
        .cyc_i    (mem_cyc),
        .stb_i    (mem_stb),
        .we_i     (mem_we),
        .addr_i   (mem_addr),
        .sel_i    (mem_sel),
        .wdata_i  (mem_wdata),
        .ack_o    (mem_ack),
        .rdata_o  (mem_rdata)
    );

endmodule

/* core_wb_bridge.sv */
`timescale 1ns/1ps

module core_wb_bridge (
    input  logic                clk_core,
    input  logic                reset_i,

    // Core side, already lane aligned
    input  logic                req_i,
    input  core_mem_pkg::addr_t addr_i,
    input  core_mem_pkg::sel_t  sel_i,
    input  logic                we_i,
    input  core_mem_pkg::data_t wdata_i,

    // Wishbone master side
    input  logic                wb_ack_i,
    input  core_mem_pkg::data_t wb_rdata_i,
    output logic                wb_cyc_o,
    output logic                wb_stb_o,
    output logic                wb_we_o,
    output core_mem_pkg::addr_t wb_addr_o,
    output core_mem_pkg::sel_t  wb_sel_o,
    output core_mem_pkg::data_t wb_wdata_o,

    // Response back to the core
    output logic                resp_o,
    output core_mem_pkg::data_t rdata_o
);

    core_mem_pkg::bridge_state_t state;

    logic start; // New request accepted this cycle

    assign start = (state == core_mem_pkg::st_idle) && req_i;

    always_ff @(posedge clk_core) begin
        if (reset_i) begin
            state    <= core_mem_pkg::st_idle;
            wb_cyc_o <= 1'b0;
            resp_o   <= 1'b0;
        end else begin
            // Ack is delayed one cycle before it reaches the core
            resp_o <= (state == core_mem_pkg::st_bus) && wb_ack_i;
            case (state)
                core_mem_pkg::st_idle: begin
                    if (req_i) begin
                        state    <= core_mem_pkg::st_bus;
                        wb_cyc_o <= 1'b1;
                    end
                end
                core_mem_pkg::st_bus: begin
                    if (wb_ack_i) begin
                        state    <= core_mem_pkg::st_resp;
                        wb_cyc_o <= 1'b0;
                    end
                end
                core_mem_pkg::st_resp: begin
                    if (!req_i) state <= core_mem_pkg::st_idle; // Core has seen resp
                end
                default: state <= core_mem_pkg::st_idle;
            endcase
        end
    end

    assign wb_stb_o = wb_cyc_o; // One transfer per cycle

    // Request payload held steady for the whole Wishbone cycle
    always_ff @(posedge clk_core) begin
        if (start) begin
            wb_addr_o  <= addr_i;
            wb_sel_o   <= sel_i;
            wb_we_o    <= we_i;
            wb_wdata_o <= wdata_i;
        end
    end

    // Read word captured with the ack
    always_ff @(posedge clk_core) begin
        if (wb_ack_i) rdata_o <= wb_rdata_i;
    end

endmodule

/* tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk_o,
    output logic reset_o
);

    initial begin
        clk_o = 1'b0;
        forever #10 clk_o = ~clk_o; // 20 ns period
    end

    // Held over the first two rising edges
    initial begin
        reset_o = 1'b1;
        repeat (2) @(posedge clk_o);
        #1 reset_o = 1'b0;
    end

endmodule

/* tb_core_mem_checker.sv */
`timescale 1ns/1ps

module tb_core_mem_checker (
    input  logic                 clk_core,
    input  logic                 reset_i,
    input  logic                 imem_req_i,
    input  core_mem_pkg::addr_t  imem_addr_i,
    input  logic                 imem_resp_i,
    input  core_mem_pkg::data_t  imem_rdata_i,
    input  logic                 dmem_req_i,
    input  logic                 dmem_cmd_i,
    input  core_mem_pkg::width_t dmem_width_i,
    input  core_mem_pkg::addr_t  dmem_addr_i,
    input  core_mem_pkg::data_t  dmem_wdata_i,
    input  logic                 dmem_resp_i,
    input  core_mem_pkg::data_t  dmem_rdata_i,
    input  logic [1:0]           exp_valid_i, // Table value present, bit 0 imem
    input  core_mem_pkg::data_t  imem_exp_i,
    input  core_mem_pkg::data_t  dmem_exp_i,
    output int                   check_count_o,
    output int                   error_count_o
);

    localparam int free_latency = 4; // req to resp with the bus idle

    core_mem_pkg::data_t  shadow [core_mem_pkg::mem_words];
    core_mem_pkg::addr_t  addr_l [2];
    core_mem_pkg::width_t width_l;
    core_mem_pkg::data_t  wdata_l;
    logic                 cmd_l;
    logic [1:0]           req;
    logic [1:0]           req_q;
    logic [1:0]           open;   // Waiting for resp
    logic [1:0]           shared; // Other port active during the request
    int                   start [2];
    int                   cycle;

    assign req = {dmem_req_i, imem_req_i};

    initial begin
        $timeformat(-9, 0, " ns", 0);
        check_count_o = 0;
        error_count_o = 0;
        cycle         = 0;
        open          = 2'b00;
    end

    task automatic compare(
        input string               name,
        input core_mem_pkg::data_t exp_v,
        input core_mem_pkg::data_t act_v
    );
        check_count_o++;
        if (act_v !== exp_v) begin
            error_count_o++;
            $display("Error at %t: %s expected %h, got %h", $time, name, exp_v, act_v);
        end
    endtask

    // Narrow data repeats in every lane, the width and low address bits pick lanes
    task automatic apply_write();
        core_mem_pkg::sel_t  sel;
        core_mem_pkg::data_t lanes;
        case (width_l)
            core_mem_pkg::width_byte: begin
                sel   = 4'b0001 << addr_l[1][1:0];
                lanes = {4{wdata_l[7:0]}};
            end
            core_mem_pkg::width_half: begin
                sel   = addr_l[1][1] ? 4'b1100 : 4'b0011;
                lanes = {2{wdata_l[15:0]}};
            end
            default: begin
                sel   = 4'b1111;
                lanes = wdata_l;
            end
        endcase
        for (int b = 0; b < 4; b++) begin
            if (sel[b]) shadow[addr_l[1][9:2]][8*b +: 8] = lanes[8*b +: 8];
        end
    endtask

    task automatic finish_request(input int p, input core_mem_pkg::data_t rdata);
        string port;
        port = (p == 0) ? "imem" : "dmem";
        if (!open[p]) begin
            error_count_o++;
            $display("Error at %t: %s response without a pending request", $time, port);
        end else begin
            open[p] = 1'b0;
            if (!shared[p]) begin
                check_count_o++;
                if (cycle - start[p] != free_latency) begin
                    error_count_o++;
                    $display("Error at %t: %s_resp_o latency expected %0d, got %0d",
                             $time, port, free_latency, cycle - start[p]);
                end
            end
            if (p == 1 && cmd_l) begin
                apply_write();
            end else begin
                compare({port, "_rdata_o"}, shadow[addr_l[p][9:2]], rdata);
                if (exp_valid_i[p]) begin
                    compare({port, "_rdata_o"}, (p == 0) ? imem_exp_i : dmem_exp_i, rdata);
                end
            end
        end
    endtask

    always @(posedge clk_core) begin
        cycle++;
        if (reset_i) begin
            // First edge still shows the power-up state
            if (cycle > 1 && (imem_resp_i !== 1'b0 || dmem_resp_i !== 1'b0)) begin
                error_count_o++;
                $display("Error at %t: response not low while reset is asserted", $time);
            end
            req_q = 2'b00;
        end else begin
            for (int p = 0; p < 2; p++) begin
                if (req[p] && !req_q[p]) begin
                    open[p]   = 1'b1;
                    shared[p] = 1'b0;
                    start[p]  = cycle;
                end
                if (req[p] && req[1-p]) shared[p] = 1'b1; // No latency check then
            end
            if (imem_req_i && !req_q[0]) addr_l[0] = imem_addr_i;
            if (dmem_req_i && !req_q[1]) begin
                addr_l[1] = dmem_addr_i;
                cmd_l     = dmem_cmd_i;
                width_l   = dmem_width_i;
                wdata_l   = dmem_wdata_i;
            end
            if (imem_resp_i) finish_request(0, imem_rdata_i);
            if (dmem_resp_i) finish_request(1, dmem_rdata_i);
            req_q = req;
        end
    end

endmodule

/* tb_core_mem_top.sv */
`timescale 1ns/1ps

module tb_core_mem_top;

    localparam int num_fixed  = 14;
    localparam int num_random = 24; // Word write, narrow write, read per address
    localparam int num_rows   = num_fixed + num_random;

    localparam core_mem_pkg::width_t wb = core_mem_pkg::width_byte;
    localparam core_mem_pkg::width_t wh = core_mem_pkg::width_half;
    localparam core_mem_pkg::width_t wd = core_mem_pkg::width_word;

    typedef struct packed {
        logic [1:0]           mask;  // Bit 0 imem, bit 1 dmem
        logic                 cmd;
        core_mem_pkg::width_t width;
        core_mem_pkg::addr_t  iaddr;
        core_mem_pkg::addr_t  daddr;
        core_mem_pkg::data_t  wdata;
        logic [1:0]           chk;   // Ports with an expected word
        core_mem_pkg::data_t  iexp;
        core_mem_pkg::data_t  dexp;
    } row_t;

    row_t                 rows [$];
    logic                 clk_core;
    logic                 reset_i;
    logic                 imem_req_i;
    core_mem_pkg::addr_t  imem_addr_i;
    logic                 imem_resp_o;
    core_mem_pkg::data_t  imem_rdata_o;
    logic                 dmem_req_i;
    logic                 dmem_cmd_i;
    core_mem_pkg::width_t dmem_width_i;
    core_mem_pkg::addr_t  dmem_addr_i;
    core_mem_pkg::data_t  dmem_wdata_i;
    logic                 dmem_resp_o;
    core_mem_pkg::data_t  dmem_rdata_o;
    logic [1:0]           exp_valid;
    core_mem_pkg::data_t  imem_exp;
    core_mem_pkg::data_t  dmem_exp;
    int                   check_count;
    int                   error_count;

    tb_clock_gen clock_inst (.clk_o(clk_core), .reset_o(reset_i));

    core_mem_top core_mem_top_inst (.*);

    tb_core_mem_checker monitor_inst (
        .clk_core      (clk_core),
        .reset_i       (reset_i),
        .imem_req_i    (imem_req_i),
        .imem_addr_i   (imem_addr_i),
        .imem_resp_i   (imem_resp_o),
        .imem_rdata_i  (imem_rdata_o),
        .dmem_req_i    (dmem_req_i),
        .dmem_cmd_i    (dmem_cmd_i),
        .dmem_width_i  (dmem_width_i),
        .dmem_addr_i   (dmem_addr_i),
        .dmem_wdata_i  (dmem_wdata_i),
        .dmem_resp_i   (dmem_resp_o),
        .dmem_rdata_i  (dmem_rdata_o),
        .exp_valid_i   (exp_valid),
        .imem_exp_i    (imem_exp),
        .dmem_exp_i    (dmem_exp),
        .check_count_o (check_count),
        .error_count_o (error_count)
    );

    task automatic apply_row(input row_t r);
        imem_req_i   = r.mask[0];
        imem_addr_i  = r.iaddr;
        dmem_req_i   = r.mask[1];
        dmem_cmd_i   = r.cmd;
        dmem_width_i = r.width;
        dmem_addr_i  = r.daddr;
        dmem_wdata_i = r.wdata;
        exp_valid    = r.chk;
        imem_exp     = r.iexp;
        dmem_exp     = r.dexp;
    endtask

    task automatic wait_resp(input logic [1:0] mask);
        logic [1:0] seen;
        seen = 2'b00;
        while ((seen & mask) != mask) begin
            @(posedge clk_core);
            if (imem_resp_o === 1'b1) seen[0] = 1'b1;
            if (dmem_resp_o === 1'b1) seen[1] = 1'b1;
        end
    endtask

    initial begin : drive
        core_mem_pkg::addr_t base;
        core_mem_pkg::addr_t naddr;
        core_mem_pkg::width_t nw;
        core_mem_pkg::data_t d0;
        core_mem_pkg::data_t d1;
        apply_row('0);
        void'($urandom(83362));
        // mask, cmd, width, iaddr, daddr, wdata, chk, iexp, dexp
        rows.push_back(row_t'{2'b10, 1'b1, wd, 'h0, 'h10, 'h1122_3344, 2'b00, 'h0, 'h0});
        rows.push_back(row_t'{2'b10, 1'b0, wd, 'h0, 'h10, 'h0, 2'b10, 'h0, 'h1122_3344});
        rows.push_back(row_t'{2'b01, 1'b0, wd, 'h10, 'h0, 'h0, 2'b01, 'h1122_3344, 'h0});
        rows.push_back(row_t'{2'b10, 1'b1, wb, 'h0, 'h11, 'hffff_ffab, 2'b00, 'h0, 'h0});
        rows.push_back(row_t'{2'b10, 1'b1, wh, 'h0, 'h12, 'h9999_cdef, 2'b00, 'h0, 'h0});
        rows.push_back(row_t'{2'b10, 1'b0, wd, 'h0, 'h10, 'h0, 2'b10, 'h0, 'hcdef_ab44});
        rows.push_back(row_t'{2'b10, 1'b1, wd, 'h0, 'h20, 'ha5a5_5a5a, 2'b00, 'h0, 'h0});
        rows.push_back(row_t'{2'b10, 1'b1, wb, 'h0, 'h20, 'h0000_0077, 2'b00, 'h0, 'h0});
        rows.push_back(row_t'{2'b10, 1'b1, wh, 'h0, 'h20, 'h0000_1234, 2'b00, 'h0, 'h0});
        rows.push_back(row_t'{2'b10, 1'b1, wb, 'h0, 'h23, 'h0000_00fe, 2'b00, 'h0, 'h0});
        // Both ports in one row
        rows.push_back(row_t'{2'b11, 1'b0, wd, 'h10, 'h22, 'h0, 2'b11, 'hcdef_ab44, 'hfea5_1234});
        rows.push_back(row_t'{2'b11, 1'b1, wd, 'h20, 'h30, 'hdead_beef, 2'b01, 'hfea5_1234, 'h0});
        rows.push_back(row_t'{2'b11, 1'b0, wd, 'h30, 'h13, 'h0, 2'b11, 'hdead_beef, 'hcdef_ab44});
        rows.push_back(row_t'{2'b01, 1'b0, wd, 'h30, 'h0, 'h0, 2'b01, 'hdead_beef, 'h0});
        for (int i = 0; i < num_random / 3; i++) begin
            base  = ($urandom % core_mem_pkg::mem_words) * 4;
            naddr = base + ($urandom % 4);
            nw    = core_mem_pkg::width_t'($urandom % 2); // Byte or halfword
            d0    = $urandom;
            d1    = $urandom;
            rows.push_back(row_t'{2'b10, 1'b1, wd, 'h0, base, d0, 2'b00, 'h0, 'h0});
            rows.push_back(row_t'{2'b10, 1'b1, nw, 'h0, naddr, d1, 2'b00, 'h0, 'h0});
            rows.push_back(row_t'{2'b10, 1'b0, wd, 'h0, base, 'h0, 2'b00, 'h0, 'h0});
        end
        @(negedge reset_i);
        @(posedge clk_core);
        #1;
        foreach (rows[r]) begin
            apply_row(rows[r]);
            wait_resp(rows[r].mask);
            #1;
            imem_req_i = 1'b0;
            dmem_req_i = 1'b0;
            @(posedge clk_core);
            #1;
        end
        repeat (2) @(posedge clk_core);
        $display("Checks: %0d  Errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    initial begin : watchdog
        #(num_rows * 40 * 20);
        $display("Timeout: the rows did not complete in the allowed time");
        $display("Checks: %0d  Errors: %0d", check_count, error_count);
        $display("Errors found");
        $finish;
    end

endmodule

/* verilog.f */
core_mem_pkg.sv
core_lane_aligner.sv
core_wb_bridge.sv
wb_rr_arbiter.sv
wb_sram.sv
core_mem_top.sv
tb_clock_gen.sv
tb_core_mem_checker.sv
tb_core_mem_top.sv

/* wb_rr_arbiter.sv */
`timescale 1ns/1ps

module wb_rr_arbiter (
    input  logic                clk_core,
    input  logic                reset_i,

    // One Wishbone master per port bridge
    input  logic [core_mem_pkg::num_ports-1:0] m_cyc_i,
    input  logic [core_mem_pkg::num_ports-1:0] m_stb_i,
    input  logic [core_mem_pkg::num_ports-1:0] m_we_i,
    input  core_mem_pkg::addr_t m_addr_i  [core_mem_pkg::num_ports],
    input  core_mem_pkg::sel_t  m_sel_i   [core_mem_pkg::num_ports],
    input  core_mem_pkg::data_t m_wdata_i [core_mem_pkg::num_ports],
    output logic [core_mem_pkg::num_ports-1:0] m_ack_o,
    output core_mem_pkg::data_t m_rdata_o [core_mem_pkg::num_ports],

    // Shared bus towards the memory
    input  logic                s_ack_i,
    input  core_mem_pkg::data_t s_rdata_i,
    output logic                s_cyc_o,
    output logic                s_stb_o,
    output logic                s_we_o,
    output core_mem_pkg::addr_t s_addr_o,
    output core_mem_pkg::sel_t  s_sel_o,
    output core_mem_pkg::data_t s_wdata_o
);

    core_mem_pkg::port_idx_t owner;      // Current or last granted port
    core_mem_pkg::port_idx_t next_owner;
    logic                    next_valid;
    logic                    busy;

    // First requesting port after the last owner
    always_comb begin : pick
        int unsigned cand;
        next_valid = 1'b0;
        next_owner = owner;
        // Walk backwards so the nearest candidate wins
        for (int i = core_mem_pkg::num_ports; i >= 1; i--) begin
            cand = (int'(owner) + i) % core_mem_pkg::num_ports;
            if (m_cyc_i[cand]) begin
                next_valid = 1'b1;
                next_owner = core_mem_pkg::port_idx_t'(cand);
            end
        end
    end

    always_ff @(posedge clk_core) begin
        if (reset_i) begin
            busy  <= 1'b0;
            owner <= core_mem_pkg::port_idx_t'(core_mem_pkg::num_ports - 1); // Port 0 first
        end else if (!busy) begin
            if (next_valid) begin
                busy  <= 1'b1;
                owner <= next_owner;
            end
        end else if (s_ack_i) begin
            busy <= 1'b0; // Owner's transfer done
        end
    end

    // Granted master drives the shared bus
    assign s_cyc_o   = busy && m_cyc_i[owner];
    assign s_stb_o   = busy && m_stb_i[owner];
    assign s_we_o    = m_we_i[owner];
    assign s_addr_o  = m_addr_i[owner];
    assign s_sel_o   = m_sel_i[owner];
    assign s_wdata_o = m_wdata_i[owner];

    // Response goes only to the owner
    genvar p;
    generate
        for (p = 0; p < core_mem_pkg::num_ports; p++) begin : g_resp
            assign m_ack_o[p]   = s_ack_i && busy && (owner == p);
            assign m_rdata_o[p] = (owner == p) ? s_rdata_i : '0;
        end
    endgenerate

endmodule

/* wb_sram.sv */
`timescale 1ns/1ps

module wb_sram (
    input  logic                clk_core,
    input  logic                reset_i,
    input  logic                cyc_i,
    input  logic                stb_i,
    input  logic                we_i,
    input  core_mem_pkg::addr_t addr_i,
    input  core_mem_pkg::sel_t  sel_i,
    input  core_mem_pkg::data_t wdata_i,
    output logic                ack_o,
    output core_mem_pkg::data_t rdata_o
);

    core_mem_pkg::data_t mem [core_mem_pkg::mem_words];

    core_mem_pkg::mem_idx_t word_idx;
    logic                   access; // First cycle of a strobe

    assign word_idx = addr_i[2 +: $bits(core_mem_pkg::mem_idx_t)];

    // Strobe stays high during ack, so skip that cycle
    assign access = cyc_i && stb_i && !ack_o;

    always_ff @(posedge clk_core) begin
        if (reset_i) begin
            ack_o <= 1'b0;
        end else begin
            ack_o <= access;
        end
    end

    always_ff @(posedge clk_core) begin
        if (access) begin
            rdata_o <= mem[word_idx];
            if (we_i) begin
                for (int b = 0; b < 4; b++) begin
                    if (sel_i[b]) mem[word_idx][8*b +: 8] <= wdata_i[8*b +: 8];
                end
            end
        end
    end

endmodule
